/* include/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ============================================================
// Cache geometry
// ============================================================

// Line address width, one address per cache line
`define CACHE_ADDR_W   16

// Set index bits, the only real size knob
`define CACHE_SET_W    4
`define CACHE_SETS     (1 << `CACHE_SET_W)

// Tag is what is left of the line address
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_SET_W)

// Full cache line payload
`define CACHE_CL_W     64

// Transaction queue entry id
`define CACHE_TQ_ID_W  4

`endif

/* hdl/cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    // ============================================================
    // Lookup kinds and addressing
    // ============================================================

    // Lookups issued by the transaction queue
    typedef enum logic [1:0] {
        RD_LU   = 2'd0,
        WR_LU   = 2'd1,
        FILL_LU = 2'd2
    } t_lu_op;

    // Tag over set index
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic [`CACHE_SET_W-1:0] set;
    } t_addr_split;

    // Same line address, raw or split
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        t_addr_split              split;
    } t_address;

    // ============================================================
    // Queue and far memory side
    // ============================================================

    typedef struct packed {
        logic                       valid;
        t_lu_op                     lu_op;
        t_address                   address;
        logic [`CACHE_CL_W-1:0]     cl_data;
        logic [`CACHE_TQ_ID_W-1:0]  tq_id;
    } t_lu_req;

    typedef struct packed {
        logic                       valid;
        logic [`CACHE_TQ_ID_W-1:0]  tq_id;
        t_lu_op                     lu_op;
        logic                       hit;
        logic [`CACHE_CL_W-1:0]     cl_data;
    } t_lu_rsp;

    // Miss read, tq_id comes back with the fill
    typedef struct packed {
        logic                       valid;
        t_address                   address;
        logic [`CACHE_TQ_ID_W-1:0]  tq_id;
    } t_fm_rd_req;

    // Write around or dirty evict
    typedef struct packed {
        logic                       valid;
        t_address                   address;
        logic [`CACHE_CL_W-1:0]     data;
    } t_fm_wr_req;

    // ============================================================
    // Array side
    // ============================================================

    typedef struct packed {
        logic                       valid;
        logic [`CACHE_SET_W-1:0]    set;
    } t_set_rd_req;

    // One set, two ways, lru points at the way to replace
    typedef struct packed {
        logic [1:0][`CACHE_TAG_W-1:0] tag;
        logic [1:0]                   valid;
        logic [1:0]                   dirty;
        logic                         lru;
    } t_set_entry;

    typedef t_set_entry t_set_rd_rsp;

    typedef struct packed {
        logic                       valid;
        logic [`CACHE_SET_W-1:0]    set;
        t_set_entry                 entry;
    } t_set_wr_req;

    typedef struct packed {
        logic                       valid;
        logic [`CACHE_SET_W-1:0]    set;
        logic                       way;
    } t_cl_rd_req;

    typedef struct packed {
        logic [`CACHE_CL_W-1:0]     cl_data;
    } t_cl_rd_rsp;

    typedef struct packed {
        logic                       valid;
        logic [`CACHE_SET_W-1:0]    set;
        logic                       way;
        logic [`CACHE_CL_W-1:0]     cl_data;
    } t_cl_wr_req;

endpackage

`default_nettype wire

/* hdl/tag_array.sv */
`default_nettype none

`include "cache_cfg.svh"

module tag_array (
    input  wire                       clk,
    input  wire                       rst_n,
    // Set lookup from q1
    input  var cache_pkg::t_set_rd_req rd_req,
    output cache_pkg::t_set_rd_rsp     rd_rsp,
    // Whole set update from q2
    input  var cache_pkg::t_set_wr_req wr_req
);

    // ============================================================
    // Set storage
    // ============================================================

    // Tags, state bits and lru per set
    cache_pkg::t_set_entry sets [`CACHE_SETS];

    // Write of the full entry
    // Reset only clears state bits, tags are don't care while invalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                sets[i].valid <= '0;
                sets[i].dirty <= '0;
                sets[i].lru   <= 1'b0;
            end
        end else if (wr_req.valid) begin
            sets[wr_req.set] <= wr_req.entry;
        end
    end

    // ============================================================
    // Registered read
    // ============================================================

    // Old contents on same-edge write
    // Pipe forwards the new entry in that case
    always_ff @(posedge clk) begin
        if (rd_req.valid) begin
            rd_rsp <= sets[rd_req.set];
        end
    end

endmodule

`default_nettype wire

/* hdl/data_array.sv */
`default_nettype none

`include "cache_cfg.svh"

module data_array (
    input  wire                       clk,
    // Line read from q2
    input  var cache_pkg::t_cl_rd_req rd_req,
    output cache_pkg::t_cl_rd_rsp     rd_rsp,
    // Line write from q3
    input  var cache_pkg::t_cl_wr_req wr_req
);

    // ============================================================
    // Line storage
    // ============================================================

    // Indexed by set then way
    logic [`CACHE_CL_W-1:0] lines [`CACHE_SETS][2];

    // Full line write
    always_ff @(posedge clk) begin
        if (wr_req.valid) begin
            lines[wr_req.set][wr_req.way] <= wr_req.cl_data;
        end
    end

    // ============================================================
    // Registered read
    // ============================================================

    // Returns old line if written on the same edge
    // q3 forwarding covers that case
    always_ff @(posedge clk) begin
        if (rd_req.valid) begin
            rd_rsp.cl_data <= lines[rd_req.set][rd_req.way];
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_pipe.sv */
`default_nettype none

`include "cache_cfg.svh"

module cache_pipe (
    input  wire                        clk,
    input  wire                        rst_n,
    // Transaction queue
    input  var cache_pkg::t_lu_req     lu_req_q1,
    output cache_pkg::t_lu_rsp         lu_rsp_q3,
    // Far memory requests
    output cache_pkg::t_fm_wr_req      fm_wr_req_q3,
    output cache_pkg::t_fm_rd_req      fm_rd_req_q3,
    // Tag array
    output cache_pkg::t_set_rd_req     set_rd_req_q1,
    input  var cache_pkg::t_set_rd_rsp set_rd_rsp_q2,
    output cache_pkg::t_set_wr_req     set_wr_req_q2,
    // Data array
    output cache_pkg::t_cl_rd_req      cl_rd_req_q2,
    input  var cache_pkg::t_cl_rd_rsp  cl_rd_rsp_q3,
    output cache_pkg::t_cl_wr_req      cl_wr_req_q3
);

    // Decisions made in q2 and used in q3
    typedef struct packed {
        logic                    hit;
        logic                    way;
        logic                    evict;
        logic [`CACHE_TAG_W-1:0] victim_tag;
    } t_q3_ctl;

    cache_pkg::t_lu_req     lu_req_q2;
    cache_pkg::t_lu_req     lu_req_q3;
    t_q3_ctl                ctl_q2;
    t_q3_ctl                ctl_q3;

    // Set forwarding from q2 write into next q2
    logic                   set_fwd_hit_q2;
    cache_pkg::t_set_entry  set_fwd_entry_q2;
    // Line forwarding from q3 write into next q3
    logic                   cl_fwd_hit_q3;
    logic [`CACHE_CL_W-1:0] cl_fwd_data_q3;

    cache_pkg::t_set_entry  entry_q2;
    cache_pkg::t_set_entry  upd_entry_q2;
    logic [1:0]             way_hit_q2;
    logic                   is_rd_q2;
    logic                   is_wr_q2;
    logic                   is_fill_q2;
    logic                   victim_way_q2;
    logic                   used_way_q2;

    logic [`CACHE_CL_W-1:0] line_q3;
    logic                   is_rd_q3;
    logic                   is_wr_q3;
    logic                   is_fill_q3;
    cache_pkg::t_address    evict_addr_q3;

    // ============================================================
    // q1 set lookup
    // ============================================================

    assign set_rd_req_q1.valid = lu_req_q1.valid;
    assign set_rd_req_q1.set   = lu_req_q1.address.split.set;

    // Stage registers, valid bits are the only reset state
    always_ff @(posedge clk) begin
        lu_req_q2 <= lu_req_q1;
        lu_req_q3 <= lu_req_q2;
        ctl_q3    <= ctl_q2;
        if (!rst_n) begin
            lu_req_q2.valid <= 1'b0;
            lu_req_q3.valid <= 1'b0;
        end
    end

    // Same set read and written on one edge
    always_ff @(posedge clk) begin
        set_fwd_entry_q2 <= set_wr_req_q2.entry;
        if (!rst_n) begin
            set_fwd_hit_q2 <= 1'b0;
        end else begin
            set_fwd_hit_q2 <= set_wr_req_q2.valid && set_rd_req_q1.valid &&
                              (set_wr_req_q2.set == set_rd_req_q1.set);
        end
    end

    // ============================================================
    // q2 tag compare, victim, set update
    // ============================================================

    // Array read is stale under a set hazard
    assign entry_q2 = set_fwd_hit_q2 ? set_fwd_entry_q2 : set_rd_rsp_q2;

    assign is_rd_q2   = lu_req_q2.lu_op == cache_pkg::RD_LU;
    assign is_wr_q2   = lu_req_q2.lu_op == cache_pkg::WR_LU;
    assign is_fill_q2 = lu_req_q2.lu_op == cache_pkg::FILL_LU;

    // Per way tag match
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit_q2[w] = entry_q2.valid[w] &&
                            (entry_q2.tag[w] == lu_req_q2.address.split.tag);
        end
    end

    assign ctl_q2.hit = |way_hit_q2;

    // Fill reuses the matching way, else the lru way
    assign victim_way_q2 = ctl_q2.hit ? way_hit_q2[1] : entry_q2.lru;
    assign used_way_q2   = is_fill_q2 ? victim_way_q2 : way_hit_q2[1];

    assign ctl_q2.way        = used_way_q2;
    assign ctl_q2.victim_tag = entry_q2.tag[victim_way_q2];
    assign ctl_q2.evict      = is_fill_q2 && entry_q2.valid[victim_way_q2] &&
                               entry_q2.dirty[victim_way_q2];

    // New set contents
    always_comb begin
        upd_entry_q2     = entry_q2;
        // Touched way becomes MRU
        upd_entry_q2.lru = ~used_way_q2;
        if (is_wr_q2) begin
            upd_entry_q2.dirty[used_way_q2] = 1'b1;
        end
        // Fill installs a clean line
        if (is_fill_q2) begin
            upd_entry_q2.tag[used_way_q2]   = lu_req_q2.address.split.tag;
            upd_entry_q2.valid[used_way_q2] = 1'b1;
            upd_entry_q2.dirty[used_way_q2] = 1'b0;
        end
    end

    // Misses leave the set alone, no allocation on write miss
    assign set_wr_req_q2.valid = lu_req_q2.valid && (is_fill_q2 || ctl_q2.hit);
    assign set_wr_req_q2.set   = lu_req_q2.address.split.set;
    assign set_wr_req_q2.entry = upd_entry_q2;

    // Hit line for reads, victim line for fills
    assign cl_rd_req_q2.valid = lu_req_q2.valid &&
                                ((is_rd_q2 && ctl_q2.hit) || is_fill_q2);
    assign cl_rd_req_q2.set   = lu_req_q2.address.split.set;
    assign cl_rd_req_q2.way   = used_way_q2;

    // Same line read and written on one edge
    always_ff @(posedge clk) begin
        cl_fwd_data_q3 <= cl_wr_req_q3.cl_data;
        if (!rst_n) begin
            cl_fwd_hit_q3 <= 1'b0;
        end else begin
            cl_fwd_hit_q3 <= cl_wr_req_q3.valid && cl_rd_req_q2.valid &&
                             (cl_wr_req_q3.set == cl_rd_req_q2.set) &&
                             (cl_wr_req_q3.way == cl_rd_req_q2.way);
        end
    end

    // ============================================================
    // q3 response, FM requests, data write
    // ============================================================

    assign line_q3 = cl_fwd_hit_q3 ? cl_fwd_data_q3 : cl_rd_rsp_q3.cl_data;

    assign is_rd_q3   = lu_req_q3.lu_op == cache_pkg::RD_LU;
    assign is_wr_q3   = lu_req_q3.lu_op == cache_pkg::WR_LU;
    assign is_fill_q3 = lu_req_q3.lu_op == cache_pkg::FILL_LU;

    // One response per lookup
    assign lu_rsp_q3.valid   = lu_req_q3.valid;
    assign lu_rsp_q3.tq_id   = lu_req_q3.tq_id;
    assign lu_rsp_q3.lu_op   = lu_req_q3.lu_op;
    assign lu_rsp_q3.hit     = is_fill_q3 || ctl_q3.hit;
    assign lu_rsp_q3.cl_data = is_fill_q3                ? lu_req_q3.cl_data :
                               (is_rd_q3 && ctl_q3.hit) ? line_q3 : '0;

    // Read miss goes to FM with its queue id
    assign fm_rd_req_q3.valid   = lu_req_q3.valid && is_rd_q3 && !ctl_q3.hit;
    assign fm_rd_req_q3.address = lu_req_q3.address;
    assign fm_rd_req_q3.tq_id   = lu_req_q3.tq_id;

    // Victim line address
    always_comb begin
        evict_addr_q3.split.tag = ctl_q3.victim_tag;
        evict_addr_q3.split.set = lu_req_q3.address.split.set;
    end

    // Write around on miss, or dirty victim of a fill
    assign fm_wr_req_q3.valid   = lu_req_q3.valid &&
                                  ((is_wr_q3 && !ctl_q3.hit) || ctl_q3.evict);
    assign fm_wr_req_q3.address = ctl_q3.evict ? evict_addr_q3 : lu_req_q3.address;
    assign fm_wr_req_q3.data    = ctl_q3.evict ? line_q3 : lu_req_q3.cl_data;

    // Write hit or fill lands in the array
    assign cl_wr_req_q3.valid   = lu_req_q3.valid &&
                                  ((is_wr_q3 && ctl_q3.hit) || is_fill_q3);
    assign cl_wr_req_q3.set     = lu_req_q3.address.split.set;
    assign cl_wr_req_q3.way     = ctl_q3.way;
    assign cl_wr_req_q3.cl_data = lu_req_q3.cl_data;

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
`default_nettype none

module cache_top (
    input  wire                    clk,
    input  wire                    rst_n,
    // Transaction queue
    input  var cache_pkg::t_lu_req lu_req,
    output cache_pkg::t_lu_rsp     lu_rsp,
    // Far memory
    output cache_pkg::t_fm_rd_req  fm_rd_req,
    output cache_pkg::t_fm_wr_req  fm_wr_req
);

    // ============================================================
    // Pipe to array buses
    // ============================================================

    cache_pkg::t_set_rd_req set_rd_req;
    cache_pkg::t_set_rd_rsp set_rd_rsp;
    cache_pkg::t_set_wr_req set_wr_req;
    cache_pkg::t_cl_rd_req  cl_rd_req;
    cache_pkg::t_cl_rd_rsp  cl_rd_rsp;
    cache_pkg::t_cl_wr_req  cl_wr_req;

    // Three stage lookup pipe
    cache_pipe u_pipe (
        .clk           (clk),
        .rst_n         (rst_n),
        .lu_req_q1     (lu_req),
        .lu_rsp_q3     (lu_rsp),
        .fm_wr_req_q3  (fm_wr_req),
        .fm_rd_req_q3  (fm_rd_req),
        .set_rd_req_q1 (set_rd_req),
        .set_rd_rsp_q2 (set_rd_rsp),
        .set_wr_req_q2 (set_wr_req),
        .cl_rd_req_q2  (cl_rd_req),
        .cl_rd_rsp_q3  (cl_rd_rsp),
        .cl_wr_req_q3  (cl_wr_req)
    );

    // Tags and state, read in q1
    tag_array u_tag_array (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_req (set_rd_req),
        .rd_rsp (set_rd_rsp),
        .wr_req (set_wr_req)
    );

    // Lines, read in q2
    data_array u_data_array (
        .clk    (clk),
        .rd_req (cl_rd_req),
        .rd_rsp (cl_rd_rsp),
        .wr_req (cl_wr_req)
    );

endmodule

`default_nettype wire

/* tb/cache_asserts.sv */
`default_nettype none

module cache_asserts (
    input  wire                        clk,
    input  wire                        rst_n,
    input  var cache_pkg::t_lu_req     lu_req_q1,
    input  var cache_pkg::t_lu_rsp     lu_rsp_q3,
    input  var cache_pkg::t_fm_rd_req  fm_rd_req_q3,
    input  var cache_pkg::t_fm_wr_req  fm_wr_req_q3
);

    // ============================================================
    // Request tracking
    // ============================================================

    // First lookup sampled since reset
    logic req_seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_seen <= 1'b0;
        end else if (lu_req_q1.valid) begin
            req_seen <= 1'b1;
        end
    end

    // ============================================================
    // Output checks
    // ============================================================

    // Every lookup answered exactly two cycles later
    rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        lu_rsp_q3.valid == $past(lu_req_q1.valid, 2))
        else $error("lu_rsp valid does not match the request two cycles back");

    // Only one FM request per lookup
    fm_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(fm_rd_req_q3.valid && fm_wr_req_q3.valid))
        else $error("FM read and FM write valid in the same cycle");

    // Quiet outputs until traffic starts
    idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !req_seen |-> !(lu_rsp_q3.valid || fm_rd_req_q3.valid || fm_wr_req_q3.valid))
        else $error("output valid before any lookup was issued");

endmodule

bind cache_pipe cache_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .lu_req_q1    (lu_req_q1),
    .lu_rsp_q3    (lu_rsp_q3),
    .fm_rd_req_q3 (fm_rd_req_q3),
    .fm_wr_req_q3 (fm_wr_req_q3)
);

`default_nettype wire

/* tb/cache_tb.sv */
`default_nettype none

`include "cache_cfg.svh"

module cache_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 5;
    localparam int RST_CYCLES = 8;
    // Eleven hex columns per stimulus line
    localparam int COLS       = 11;
    localparam int MAX_LINES  = 48;
    localparam logic [63:0] END_MARK = 64'hf;

    logic                  clk;
    logic                  rst_n;
    cache_pkg::t_lu_req    lu_req;
    cache_pkg::t_lu_rsp    lu_rsp;
    cache_pkg::t_fm_rd_req fm_rd_req;
    cache_pkg::t_fm_wr_req fm_wr_req;

    logic [63:0]           stim [MAX_LINES*COLS];
    int                    n_lines;
    logic                  stim_loaded;

    // Expected outputs of the two lookups in flight
    cache_pkg::t_lu_rsp    exp_rsp_q [$];
    cache_pkg::t_fm_rd_req exp_fm_rd_q [$];
    cache_pkg::t_fm_wr_req exp_fm_wr_q [$];

    cache_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .lu_req    (lu_req),
        .lu_rsp    (lu_rsp),
        .fm_rd_req (fm_rd_req),
        .fm_wr_req (fm_wr_req)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ============================================================
    // Failure reporting
    // ============================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic stop_on_error(input string msg);
        abort_run($sformatf("error at time %0t: %s", $time, msg));
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic check_lu_rsp(input cache_pkg::t_lu_rsp got,
                                input cache_pkg::t_lu_rsp exp);
        if (got.valid !== exp.valid) begin
            stop_on_error($sformatf("lu_rsp valid got %0b expected %0b",
                                    got.valid, exp.valid));
        end else if (exp.valid) begin
            if (got.tq_id !== exp.tq_id) begin
                stop_on_error($sformatf("lu_rsp tq_id got %h expected %h",
                                        got.tq_id, exp.tq_id));
            end
            if (got.lu_op !== exp.lu_op) begin
                stop_on_error($sformatf("lu_rsp lu_op got %0d expected %0d",
                                        got.lu_op, exp.lu_op));
            end
            if (got.hit !== exp.hit) begin
                stop_on_error($sformatf("lu_rsp hit got %0b expected %0b (tq_id %h)",
                                        got.hit, exp.hit, exp.tq_id));
            end
            // Data only means something on read hits and fills
            if (exp.hit && exp.lu_op != cache_pkg::WR_LU &&
                got.cl_data !== exp.cl_data) begin
                stop_on_error($sformatf("lu_rsp cl_data got %h expected %h",
                                        got.cl_data, exp.cl_data));
            end
        end
    endtask

    task automatic check_fm_rd(input cache_pkg::t_fm_rd_req got,
                               input cache_pkg::t_fm_rd_req exp);
        if (got.valid !== exp.valid) begin
            stop_on_error($sformatf("fm_rd_req valid got %0b expected %0b",
                                    got.valid, exp.valid));
        end else if (exp.valid) begin
            if (got.address.raw !== exp.address.raw || got.tq_id !== exp.tq_id) begin
                stop_on_error($sformatf("fm_rd_req got %h/%h expected %h/%h",
                                        got.address.raw, got.tq_id,
                                        exp.address.raw, exp.tq_id));
            end
        end
    endtask

    task automatic check_fm_wr(input cache_pkg::t_fm_wr_req got,
                               input cache_pkg::t_fm_wr_req exp);
        if (got.valid !== exp.valid) begin
            stop_on_error($sformatf("fm_wr_req valid got %0b expected %0b",
                                    got.valid, exp.valid));
        end else if (exp.valid) begin
            if (got.address.raw !== exp.address.raw || got.data !== exp.data) begin
                stop_on_error($sformatf("fm_wr_req got %h/%h expected %h/%h",
                                        got.address.raw, got.data,
                                        exp.address.raw, exp.data));
            end
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================

    // Drive one file line and queue what it should produce
    task automatic apply_line(input int idx);
        int                    b;
        cache_pkg::t_lu_rsp    rsp;
        cache_pkg::t_fm_rd_req fm_rd;
        cache_pkg::t_fm_wr_req fm_wr;
        b = idx * COLS;
        lu_req.valid       = stim[b][0];
        lu_req.lu_op       = cache_pkg::t_lu_op'(stim[b+1][1:0]);
        lu_req.address.raw = stim[b+2][`CACHE_ADDR_W-1:0];
        lu_req.cl_data     = stim[b+3][`CACHE_CL_W-1:0];
        lu_req.tq_id       = stim[b+4][`CACHE_TQ_ID_W-1:0];
        // Id and op echo the request
        rsp.valid          = lu_req.valid;
        rsp.tq_id          = lu_req.tq_id;
        rsp.lu_op          = lu_req.lu_op;
        rsp.hit            = stim[b+5][0];
        rsp.cl_data        = stim[b+6][`CACHE_CL_W-1:0];
        // Miss read goes out with the lookup's address and id
        fm_rd.valid        = stim[b+7][0];
        fm_rd.address      = lu_req.address;
        fm_rd.tq_id        = lu_req.tq_id;
        fm_wr.valid        = stim[b+8][0];
        fm_wr.address.raw  = stim[b+9][`CACHE_ADDR_W-1:0];
        fm_wr.data         = stim[b+10][`CACHE_CL_W-1:0];
        exp_rsp_q.push_back(rsp);
        exp_fm_rd_q.push_back(fm_rd);
        exp_fm_wr_q.push_back(fm_wr);
    endtask

    // Drain cycles
    task automatic apply_idle();
        lu_req = '0;
        exp_rsp_q.push_back('0);
        exp_fm_rd_q.push_back('0);
        exp_fm_wr_q.push_back('0);
    endtask

    initial begin
        lu_req      = '0;
        rst_n       = 1'b0;
        n_lines     = 0;
        stim_loaded = 1'b0;
        $readmemh("tb/cache_input.txt", stim);
        while (n_lines < MAX_LINES && stim[n_lines*COLS] != END_MARK) begin
            n_lines++;
        end
        if (n_lines == 0 || n_lines == MAX_LINES) begin
            abort_run("stimulus file tb/cache_input.txt has no lines or no end marker");
        end
        stim_loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Results of line i show up at the drive slot of line i+2
        for (int i = 0; i < n_lines + 2; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (exp_rsp_q.size() == 2) begin
                check_lu_rsp(lu_rsp, exp_rsp_q.pop_front());
                check_fm_rd(fm_rd_req, exp_fm_rd_q.pop_front());
                check_fm_wr(fm_wr_req, exp_fm_wr_q.pop_front());
            end
            if (i < n_lines) begin
                apply_line(i);
            end else begin
                apply_idle();
            end
        end

        $display("Test completed successfully");
        $finish;
    end

    // Watchdog, sized from the stimulus length
    initial begin
        wait (stim_loaded);
        repeat (n_lines + 20) @(posedge clk);
        abort_run($sformatf("timeout: the test hung after %0d cycles", n_lines + 20));
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hdl/cache_pkg.sv
hdl/tag_array.sv
hdl/data_array.sv
hdl/cache_pipe.sv
hdl/cache_top.sv
tb/cache_asserts.sv
tb/cache_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal -j 0
TOP       := cache_tb
FILE_LIST := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
STIM      := tb/cache_input.txt
LOG       := sim.log
PASS_MSG  := Test completed successfully

SRCS := $(filter-out +%,$(shell cat $(FILE_LIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN) $(STIM)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/cache_input.txt */
// Columns: req_valid op(0 rd 1 wr 2 fill) addr data tq_id, then expected
// hit rsp_data fm_rd_valid fm_wr_valid fm_wr_addr fm_wr_data; a lone f ends the list
// Read misses after reset
1 0 1230 0000000000000000 1 0 0000000000000000 1 0 0000 0000000000000000
1 0 abc5 0000000000000000 2 0 0000000000000000 1 0 0000 0000000000000000
// Fill, idle, read hit
1 2 1230 1111111100001230 1 1 1111111100001230 0 0 0000 0000000000000000
0 0 0000 0000000000000000 0 0 0000000000000000 0 0 0000 0000000000000000
1 0 1230 0000000000000000 3 1 1111111100001230 0 0 0000 0000000000000000
// Fill then read back to back
1 2 abc5 222222220000abc5 2 1 222222220000abc5 0 0 0000 0000000000000000
1 0 abc5 0000000000000000 4 1 222222220000abc5 0 0 0000 0000000000000000
// Write hit then read of new data
1 1 1230 3333333300001230 5 1 0000000000000000 0 0 0000 0000000000000000
1 0 1230 0000000000000000 6 1 3333333300001230 0 0 0000 0000000000000000
// Write miss goes around, no allocation
1 1 4567 4444444400004567 7 0 0000000000000000 0 1 4567 4444444400004567
0 0 0000 0000000000000000 0 0 0000000000000000 0 0 0000 0000000000000000
1 0 4567 0000000000000000 8 0 0000000000000000 1 0 0000 0000000000000000
// Set 9 two fills, dirty way 1, touch way 0, third fill evicts way 1
1 2 1119 5555555500001119 9 1 5555555500001119 0 0 0000 0000000000000000
1 2 2229 6666666600002229 a 1 6666666600002229 0 0 0000 0000000000000000
1 1 2229 7777777700002229 b 1 0000000000000000 0 0 0000 0000000000000000
1 0 1119 0000000000000000 c 1 5555555500001119 0 0 0000 0000000000000000
1 2 3339 8888888800003339 d 1 8888888800003339 0 1 2229 7777777700002229
1 0 2229 0000000000000000 e 0 0000000000000000 1 0 0000 0000000000000000
1 0 3339 0000000000000000 f 1 8888888800003339 0 0 0000 0000000000000000
// Sets 0 and 5 alternating every cycle
1 0 1230 0000000000000000 1 1 3333333300001230 0 0 0000 0000000000000000
1 0 abc5 0000000000000000 2 1 222222220000abc5 0 0 0000 0000000000000000
1 1 1230 aaaaaaaa00001230 3 1 0000000000000000 0 0 0000 0000000000000000
1 1 abc5 bbbbbbbb0000abc5 4 1 0000000000000000 0 0 0000 0000000000000000
1 0 1230 0000000000000000 5 1 aaaaaaaa00001230 0 0 0000 0000000000000000
1 0 abc5 0000000000000000 6 1 bbbbbbbb0000abc5 0 0 0000 0000000000000000
// Set 0 fill into free way, then fill evicting dirty way 0
1 2 5550 dddddddd00005550 9 1 dddddddd00005550 0 0 0000 0000000000000000
1 2 6660 eeeeeeee00006660 a 1 eeeeeeee00006660 0 1 1230 aaaaaaaa00001230
1 0 1230 0000000000000000 b 0 0000000000000000 1 0 0000 0000000000000000
1 0 5550 0000000000000000 c 1 dddddddd00005550 0 0 0000 0000000000000000
1 0 6660 0000000000000000 d 1 eeeeeeee00006660 0 0 0000 0000000000000000
// End of stimulus
f
